//--- core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic              clk,
    input  logic              arst_n_i,
    output cpu_pkg::bus_req_t ibus_req_o,
    input  cpu_pkg::bus_rsp_t ibus_rsp_i,
    output cpu_pkg::bus_req_t dbus_req_o,
    input  cpu_pkg::bus_rsp_t dbus_rsp_i,
    output cpu_pkg::debug_t   debug_o
);

    logic [cpu_pkg::XLEN-1:0]   if_pc;
    logic [cpu_pkg::XLEN-1:0]   if_inst;
    logic                       id_branch;
    logic [cpu_pkg::XLEN-1:0]   id_branch_addr;
    logic [cpu_pkg::REGF_W-1:0] id_rs_regf;
    logic [cpu_pkg::REGF_W-1:0] id_rt_regf;
    logic [cpu_pkg::XLEN-1:0]   rf_rs_data;
    logic [cpu_pkg::XLEN-1:0]   rf_rt_data;
    cpu_pkg::pipe_info_t        id_info;
    logic [cpu_pkg::XLEN-1:0]   id_rs_val;
    logic [cpu_pkg::XLEN-1:0]   id_rt_val;
    logic [cpu_pkg::XLEN-1:0]   id_imm;
    cpu_pkg::ex_mm_t            ex_out;
    cpu_pkg::wb_t               fwd_ex;
    cpu_pkg::wb_t               fwd_mm;
    cpu_pkg::wb_t               wb;
    logic                       mm_except;
    logic                       mm_load;
    logic                       load_use;
    logic                       c_pc_stall;
    logic                       c_pc_flush;
    logic                       c_if_id_stall;
    logic                       c_if_id_flush;
    logic                       c_id_ex_stall;
    logic                       c_id_ex_flush;
    logic                       c_ex_mm_stall;
    logic                       c_ex_mm_flush;
    logic                       c_mm_wb_stall;

    // LW in EX or MM whose result ID needs
    assign load_use = (ex_out.info.oper == cpu_pkg::OPER_LW && fwd_ex.we &&
                       (fwd_ex.rd_regf == id_rs_regf || fwd_ex.rd_regf == id_rt_regf)) ||
                      (mm_load && fwd_mm.we &&
                       (fwd_mm.rd_regf == id_rs_regf || fwd_mm.rd_regf == id_rt_regf));

    fetch_stage fetch_ (
        .clk(clk), .arst_n_i(arst_n_i),
        .stall_i(c_pc_stall), .branch_i(id_branch), .branch_addr_i(id_branch_addr),
        .except_i(c_pc_flush), .ibus_req_o(ibus_req_o), .ibus_rsp_i(ibus_rsp_i),
        .pc_o(if_pc), .inst_o(if_inst));

    decode_stage decode_ (
        .clk(clk), .arst_n_i(arst_n_i),
        .stall_i(c_if_id_stall), .flush_i(c_if_id_flush), .pc_i(if_pc), .inst_i(if_inst),
        .rs_regf_o(id_rs_regf), .rt_regf_o(id_rt_regf),
        .rs_data_i(rf_rs_data), .rt_data_i(rf_rt_data),
        .fwd_ex_i(fwd_ex), .fwd_mm_i(fwd_mm), .fwd_wb_i(wb),
        .branch_o(id_branch), .branch_addr_o(id_branch_addr), .info_o(id_info),
        .rs_val_o(id_rs_val), .rt_val_o(id_rt_val), .imm_o(id_imm));

    reg_file regf_ (
        .clk(clk), .arst_n_i(arst_n_i),
        .rs_regf_i(id_rs_regf), .rt_regf_i(id_rt_regf),
        .rs_data_o(rf_rs_data), .rt_data_o(rf_rt_data), .wr_i(wb));

    execute_stage execute_ (
        .clk(clk), .arst_n_i(arst_n_i),
        .stall_i(c_id_ex_stall), .flush_i(c_id_ex_flush), .info_i(id_info),
        .rs_val_i(id_rs_val), .rt_val_i(id_rt_val), .imm_i(id_imm),
        .ex_o(ex_out), .fwd_o(fwd_ex));

    memory_stage memory_ (
        .clk(clk), .arst_n_i(arst_n_i),
        .stall_mm_i(c_ex_mm_stall), .flush_mm_i(c_ex_mm_flush), .stall_wb_i(c_mm_wb_stall),
        .ex_i(ex_out), .dbus_req_o(dbus_req_o), .dbus_rsp_i(dbus_rsp_i),
        .except_o(mm_except), .load_mm_o(mm_load), .fwd_mm_o(fwd_mm),
        .wb_o(wb), .debug_o(debug_o));

    hazard_unit control_ (
        .ibus_stall_i(ibus_rsp_i.stall), .dbus_stall_i(dbus_rsp_i.stall),
        .load_use_i(load_use), .branch_i(id_branch), .except_i(mm_except),
        .pc_stall_o(c_pc_stall), .pc_flush_o(c_pc_flush),
        .if_id_stall_o(c_if_id_stall), .if_id_flush_o(c_if_id_flush),
        .id_ex_stall_o(c_id_ex_stall), .id_ex_flush_o(c_id_ex_flush),
        .ex_mm_stall_o(c_ex_mm_stall), .ex_mm_flush_o(c_ex_mm_flush),
        .mm_wb_stall_o(c_mm_wb_stall), .mm_wb_flush_o());

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN   = 32;
    localparam int REGF_W = 5;

    localparam logic [XLEN-1:0] RESET_PC   = 32'h0000_0000;
    localparam logic [XLEN-1:0] EXC_VECTOR = 32'h0000_0180;

    // MIPS opcode and funct codes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_OR      = 6'h25;

    typedef enum logic [3:0] {
        OPER_NOP,   // must stay zero, a flushed register reads as NOP
        OPER_ADDU,
        OPER_SUBU,
        OPER_OR,
        OPER_ORI,
        OPER_LUI,
        OPER_LW,
        OPER_SW,
        OPER_BEQ,
        OPER_RI
    } oper_e;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [REGF_W-1:0] rs;
        logic [REGF_W-1:0] rt;
        logic [REGF_W-1:0] rd;
        logic [4:0]        shamt;
        logic [5:0]        funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [REGF_W-1:0] rs;
        logic [REGF_W-1:0] rt;
        logic [15:0]       imm16;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    typedef struct packed {
        logic            en;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data_w;
    } bus_req_t;

    typedef struct packed {
        logic [XLEN-1:0] data_r;  // answers the previous cycle's request
        logic            stall;
    } bus_rsp_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        oper_e             oper;
        logic [REGF_W-1:0] rd_regf;
    } pipe_info_t;

    typedef struct packed {
        pipe_info_t      info;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] store_data;
    } ex_mm_t;

    typedef struct packed {
        logic [REGF_W-1:0] rd_regf;
        logic              we;
        logic [XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic              we;
        logic [REGF_W-1:0] regf;
        logic [XLEN-1:0]   data;
    } debug_t;

endpackage

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       stall_i,
    input  logic                       flush_i,
    input  logic [cpu_pkg::XLEN-1:0]   pc_i,
    input  logic [cpu_pkg::XLEN-1:0]   inst_i,
    output logic [cpu_pkg::REGF_W-1:0] rs_regf_o,
    output logic [cpu_pkg::REGF_W-1:0] rt_regf_o,
    input  logic [cpu_pkg::XLEN-1:0]   rs_data_i,
    input  logic [cpu_pkg::XLEN-1:0]   rt_data_i,
    input  cpu_pkg::wb_t               fwd_ex_i,
    input  cpu_pkg::wb_t               fwd_mm_i,
    input  cpu_pkg::wb_t               fwd_wb_i,
    output logic                       branch_o,
    output logic [cpu_pkg::XLEN-1:0]   branch_addr_o,
    output cpu_pkg::pipe_info_t        info_o,
    output logic [cpu_pkg::XLEN-1:0]   rs_val_o,
    output logic [cpu_pkg::XLEN-1:0]   rt_val_o,
    output logic [cpu_pkg::XLEN-1:0]   imm_o
);

    cpu_pkg::inst_u               inst;
    logic [cpu_pkg::XLEN-1:0]     pc_q;
    cpu_pkg::oper_e               oper;
    logic [cpu_pkg::REGF_W-1:0]   rd;
    logic [cpu_pkg::XLEN-1:0]     sext;

    // Youngest producer wins
    function automatic logic [cpu_pkg::XLEN-1:0] fwd_sel(
        input logic [cpu_pkg::REGF_W-1:0] regf,
        input logic [cpu_pkg::XLEN-1:0]   rf_data,
        input cpu_pkg::wb_t               ex,
        input cpu_pkg::wb_t               mm,
        input cpu_pkg::wb_t               wb
    );
        if (regf == '0)
            return rf_data;
        if (ex.we && ex.rd_regf == regf)
            return ex.data;
        if (mm.we && mm.rd_regf == regf)
            return mm.data;
        if (wb.we && wb.rd_regf == regf)
            return wb.data;
        return rf_data;
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            pc_q <= cpu_pkg::RESET_PC;
        else if (flush_i)
            pc_q <= '0;
        else if (!stall_i)
            pc_q <= pc_i;
    end

    assign inst      = inst_i;
    assign rs_regf_o = inst.i.rs;
    assign rt_regf_o = inst.i.rt;

    always_comb begin
        oper = cpu_pkg::OPER_RI;
        rd   = inst.i.rt;    // I-format writes rt
        case (inst.r.opcode)
            cpu_pkg::OP_SPECIAL: begin
                rd = inst.r.rd;
                case (inst.r.funct)
                    cpu_pkg::FN_ADDU: oper = cpu_pkg::OPER_ADDU;
                    cpu_pkg::FN_SUBU: oper = cpu_pkg::OPER_SUBU;
                    cpu_pkg::FN_OR:   oper = cpu_pkg::OPER_OR;
                    default:          oper = cpu_pkg::OPER_RI;
                endcase
            end
            cpu_pkg::OP_ORI: oper = cpu_pkg::OPER_ORI;
            cpu_pkg::OP_LUI: oper = cpu_pkg::OPER_LUI;
            cpu_pkg::OP_LW:  oper = cpu_pkg::OPER_LW;
            cpu_pkg::OP_SW:  oper = cpu_pkg::OPER_SW;
            cpu_pkg::OP_BEQ: oper = cpu_pkg::OPER_BEQ;
            default:         oper = cpu_pkg::OPER_RI;
        endcase
        if (inst == '0)
            oper = cpu_pkg::OPER_NOP;  // bubble or sll $0
        if (oper == cpu_pkg::OPER_NOP || oper == cpu_pkg::OPER_SW ||
            oper == cpu_pkg::OPER_BEQ || oper == cpu_pkg::OPER_RI)
            rd = '0;
    end

    assign sext = {{16{inst.i.imm16[15]}}, inst.i.imm16};

    always_comb begin
        case (oper)
            cpu_pkg::OPER_ORI: imm_o = {16'h0000, inst.i.imm16};
            cpu_pkg::OPER_LUI: imm_o = {inst.i.imm16, 16'h0000};
            default:           imm_o = sext;
        endcase
    end

    assign rs_val_o = fwd_sel(rs_regf_o, rs_data_i, fwd_ex_i, fwd_mm_i, fwd_wb_i);
    assign rt_val_o = fwd_sel(rt_regf_o, rt_data_i, fwd_ex_i, fwd_mm_i, fwd_wb_i);

    // No delay slot, so the fall-through word is flushed on a taken branch
    assign branch_o      = (oper == cpu_pkg::OPER_BEQ) && (rs_val_o == rt_val_o);
    assign branch_addr_o = pc_q + 32'd4 + {sext[cpu_pkg::XLEN-3:0], 2'b00};

    assign info_o = '{pc: pc_q, oper: oper, rd_regf: rd};

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     stall_i,
    input  logic                     flush_i,
    input  cpu_pkg::pipe_info_t      info_i,
    input  logic [cpu_pkg::XLEN-1:0] rs_val_i,
    input  logic [cpu_pkg::XLEN-1:0] rt_val_i,
    input  logic [cpu_pkg::XLEN-1:0] imm_i,
    output cpu_pkg::ex_mm_t          ex_o,
    output cpu_pkg::wb_t             fwd_o
);

    cpu_pkg::pipe_info_t      info_q;
    logic [cpu_pkg::XLEN-1:0] rs_q;
    logic [cpu_pkg::XLEN-1:0] rt_q;
    logic [cpu_pkg::XLEN-1:0] imm_q;
    logic [cpu_pkg::XLEN-1:0] result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            info_q <= '0;
        else if (flush_i)
            info_q <= '0;   // bubble
        else if (!stall_i)
            info_q <= info_i;
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            rs_q  <= rs_val_i;
            rt_q  <= rt_val_i;
            imm_q <= imm_i;
        end
    end

    always_comb begin
        case (info_q.oper)
            cpu_pkg::OPER_ADDU: result = rs_q + rt_q;
            cpu_pkg::OPER_SUBU: result = rs_q - rt_q;
            cpu_pkg::OPER_OR:   result = rs_q | rt_q;
            cpu_pkg::OPER_ORI:  result = rs_q | imm_q;
            cpu_pkg::OPER_LUI:  result = imm_q;
            cpu_pkg::OPER_LW,
            cpu_pkg::OPER_SW:   result = rs_q + imm_q; // effective address
            default:            result = '0;
        endcase
    end

    assign ex_o  = '{info: info_q, result: result, store_data: rt_q};
    assign fwd_o = '{rd_regf: info_q.rd_regf, we: (info_q.rd_regf != '0), data: result};

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     stall_i,
    input  logic                     branch_i,
    input  logic [cpu_pkg::XLEN-1:0] branch_addr_i,
    input  logic                     except_i,
    output cpu_pkg::bus_req_t        ibus_req_o,
    input  cpu_pkg::bus_rsp_t        ibus_rsp_i,
    output logic [cpu_pkg::XLEN-1:0] pc_o,
    output logic [cpu_pkg::XLEN-1:0] inst_o
);

    logic                     run_q;
    logic [cpu_pkg::XLEN-1:0] pc_q;
    logic                     stall_d;
    logic                     flush_d;
    logic [cpu_pkg::XLEN-1:0] inst_save;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q   <= 1'b0;
            pc_q    <= cpu_pkg::RESET_PC;
            stall_d <= 1'b0;
            flush_d <= 1'b1;
        end else begin
            run_q   <= 1'b1;
            stall_d <= stall_i;
            flush_d <= ~run_q | except_i | (~stall_i & branch_i); // drop the word in flight
            if (except_i)
                pc_q <= cpu_pkg::EXC_VECTOR;
            else if (run_q && !stall_i)
                pc_q <= branch_i ? branch_addr_i : pc_q + 32'd4;
        end
    end

    // Word seen by ID while IF/ID is frozen
    always_ff @(posedge clk) begin
        inst_save <= inst_o;
    end

    assign inst_o = flush_d ? '0 : stall_d ? inst_save : ibus_rsp_i.data_r;
    assign pc_o   = pc_q;

    assign ibus_req_o = '{en: run_q, we: 1'b0, addr: pc_q, data_w: '0};

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic ibus_stall_i,
    input  logic dbus_stall_i,
    input  logic load_use_i,
    input  logic branch_i,
    input  logic except_i,
    output logic pc_stall_o,
    output logic pc_flush_o,
    output logic if_id_stall_o,
    output logic if_id_flush_o,
    output logic id_ex_stall_o,
    output logic id_ex_flush_o,
    output logic ex_mm_stall_o,
    output logic ex_mm_flush_o,
    output logic mm_wb_stall_o,
    output logic mm_wb_flush_o
);

    logic bus_stall;

    assign bus_stall = ibus_stall_i | dbus_stall_i;   // freezes everything

    // Exception beats load-use, which beats branch
    assign pc_stall_o    = bus_stall | (load_use_i & ~except_i);
    assign pc_flush_o    = ~bus_stall & except_i;
    assign if_id_stall_o = pc_stall_o;
    assign if_id_flush_o = ~bus_stall & (except_i | (branch_i & ~load_use_i));
    assign id_ex_stall_o = bus_stall;
    assign id_ex_flush_o = ~bus_stall & (except_i | load_use_i);
    assign ex_mm_stall_o = bus_stall;
    assign ex_mm_flush_o = ~bus_stall & except_i;
    assign mm_wb_stall_o = bus_stall;
    assign mm_wb_flush_o = 1'b0;   // faulting write is dropped inside MM

endmodule

//--- memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stall_mm_i,
    input  logic              flush_mm_i,
    input  logic              stall_wb_i,
    input  cpu_pkg::ex_mm_t   ex_i,
    output cpu_pkg::bus_req_t dbus_req_o,
    input  cpu_pkg::bus_rsp_t dbus_rsp_i,
    output logic              except_o,
    output logic              load_mm_o,
    output cpu_pkg::wb_t      fwd_mm_o,
    output cpu_pkg::wb_t      wb_o,
    output cpu_pkg::debug_t   debug_o
);

    cpu_pkg::pipe_info_t      mm_info;
    logic [cpu_pkg::XLEN-1:0] mm_result;
    logic [cpu_pkg::XLEN-1:0] mm_store;
    logic                     is_mem;
    logic                     fault;
    cpu_pkg::pipe_info_t      wb_info;
    logic                     wb_we;
    logic [cpu_pkg::XLEN-1:0] wb_result;
    logic                     stall_d;
    logic [cpu_pkg::XLEN-1:0] ld_save;
    logic [cpu_pkg::XLEN-1:0] ld_data;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            mm_info <= '0;
        else if (flush_mm_i)
            mm_info <= '0;
        else if (!stall_mm_i)
            mm_info <= ex_i.info;
    end

    always_ff @(posedge clk) begin
        if (!stall_mm_i) begin
            mm_result <= ex_i.result;
            mm_store  <= ex_i.store_data;
        end
    end

    assign is_mem   = (mm_info.oper == cpu_pkg::OPER_LW) || (mm_info.oper == cpu_pkg::OPER_SW);
    assign fault    = (mm_info.oper == cpu_pkg::OPER_RI) || (is_mem && mm_result[1:0] != 2'b00);
    assign except_o = fault;

    // Faulting access never reaches the bus
    assign dbus_req_o = '{en:     is_mem & ~fault,
                          we:     mm_info.oper == cpu_pkg::OPER_SW,
                          addr:   mm_result,
                          data_w: mm_store};

    assign load_mm_o = (mm_info.oper == cpu_pkg::OPER_LW);
    assign fwd_mm_o  = '{rd_regf: mm_info.rd_regf, we: (mm_info.rd_regf != '0), data: mm_result};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_info <= '0;
            wb_we   <= 1'b0;
            stall_d <= 1'b0;
        end else begin
            stall_d <= stall_wb_i;
            if (!stall_wb_i) begin
                wb_info <= mm_info;
                wb_we   <= (mm_info.rd_regf != '0) && !fault;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_wb_i)
            wb_result <= mm_result;
        ld_save <= ld_data;
    end

    // Load data arrived before the freeze is replayed from the held copy
    assign ld_data = stall_d ? ld_save : dbus_rsp_i.data_r;

    assign wb_o = '{rd_regf: wb_info.rd_regf,
                    we:      wb_we,
                    data:    (wb_info.oper == cpu_pkg::OPER_LW) ? ld_data : wb_result};

    assign debug_o = '{pc:   wb_info.pc,
                       we:   wb_we & ~stall_d,   // once per retirement
                       regf: wb_info.rd_regf,
                       data: wb_o.data};

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic [cpu_pkg::REGF_W-1:0] rs_regf_i,
    input  logic [cpu_pkg::REGF_W-1:0] rt_regf_i,
    output logic [cpu_pkg::XLEN-1:0]   rs_data_o,
    output logic [cpu_pkg::XLEN-1:0]   rt_data_o,
    input  cpu_pkg::wb_t               wr_i
);

    logic [cpu_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            regs <= '{default: '0};
        else if (wr_i.we && wr_i.rd_regf != '0)
            regs[wr_i.rd_regf] <= wr_i.data;
    end

    // Write-before-read bypass
    assign rs_data_o = (rs_regf_i == '0) ? '0 :
                       (wr_i.we && wr_i.rd_regf == rs_regf_i) ? wr_i.data : regs[rs_regf_i];
    assign rt_data_o = (rt_regf_i == '0) ? '0 :
                       (wr_i.we && wr_i.rd_regf == rt_regf_i) ? wr_i.data : regs[rt_regf_i];

endmodule

//--- sources.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
core_top.sv
tb_bus_memory.sv
tb_core.sv

//--- tb_bus_memory.sv
`timescale 1ns/1ps

module tb_bus_memory #(
    parameter int WORDS     = 256,
    parameter int STALL_MAX = 60    // stall cycles per bus and per run
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stall_en_i,
    input  cpu_pkg::bus_req_t ibus_req_i,
    output cpu_pkg::bus_rsp_t ibus_rsp_o,
    input  cpu_pkg::bus_req_t dbus_req_i,
    output cpu_pkg::bus_rsp_t dbus_rsp_o
);

    logic [31:0] mem [WORDS];
    logic [31:0] ibus_data;
    logic [31:0] dbus_data;
    logic        ibus_stall;
    logic        dbus_stall;
    int          ibus_budget;
    int          dbus_budget;

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ibus_stall  <= 1'b0;
            dbus_stall  <= 1'b0;
            ibus_budget <= STALL_MAX;
            dbus_budget <= STALL_MAX;
        end else begin
            ibus_stall <= stall_en_i && ibus_budget > 0 && ($urandom % 4 == 0);
            dbus_stall <= stall_en_i && dbus_budget > 0 && ($urandom % 5 == 0);
            if (ibus_stall)
                ibus_budget <= ibus_budget - 1;
            if (dbus_stall)
                dbus_budget <= dbus_budget - 1;
        end
    end

    // One cycle read latency
    always @(posedge clk) begin
        if (ibus_req_i.en)
            ibus_data <= mem[ibus_req_i.addr[9:2]];
        if (dbus_req_i.en) begin
            if (dbus_req_i.we && !dbus_stall)
                mem[dbus_req_i.addr[9:2]] <= dbus_req_i.data_w;
            dbus_data <= mem[dbus_req_i.addr[9:2]];
        end
    end

    assign ibus_rsp_o = '{data_r: ibus_data, stall: ibus_stall};
    assign dbus_rsp_o = '{data_r: dbus_data, stall: dbus_stall};

endmodule

//--- tb_core.sv
`timescale 1ns/1ps

module tb_core;

    localparam int WORDS     = 256;
    localparam int STALL_MAX = 60;
    localparam int DRAIN     = 20;   // idle cycles that catch late extra writes

    logic              clk;
    logic              arst_n;
    logic              stall_en;
    cpu_pkg::bus_req_t ibus_req;
    cpu_pkg::bus_rsp_t ibus_rsp;
    cpu_pkg::bus_req_t dbus_req;
    cpu_pkg::bus_rsp_t dbus_rsp;
    cpu_pkg::debug_t   debug_o;

    logic [31:0]       image [WORDS];
    cpu_pkg::debug_t   exp_list[$];
    int                exp_idx;
    int                errors;
    int                failed_tests;
    int                steps;
    int                cycles;
    int                cycle_limit;

    core_top core_top_inst (
        .clk(clk), .arst_n_i(arst_n),
        .ibus_req_o(ibus_req), .ibus_rsp_i(ibus_rsp),
        .dbus_req_o(dbus_req), .dbus_rsp_i(dbus_rsp),
        .debug_o(debug_o));

    tb_bus_memory #(.WORDS(WORDS), .STALL_MAX(STALL_MAX)) bus_memory (
        .clk(clk), .arst_n_i(arst_n), .stall_en_i(stall_en),
        .ibus_req_i(ibus_req), .ibus_rsp_o(ibus_rsp),
        .dbus_req_i(dbus_req), .dbus_rsp_o(dbus_rsp));

    always #20 clk = ~clk;

    function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
                                          input logic [5:0] funct);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] enc_beq(input int rs, input int rt,
                                            input logic [31:0] pc, input logic [31:0] target);
        logic [31:0] diff;
        diff = target - pc - 32'd4;
        return enc_i(6'h04, rs, rt, diff[17:2]);
    endfunction

    function automatic bit matches_expected(input cpu_pkg::debug_t dbg, input int idx);
        if (idx >= exp_list.size())
            return 1'b0;
        return dbg.pc == exp_list[idx].pc && dbg.regf == exp_list[idx].regf &&
               dbg.data == exp_list[idx].data;
    endfunction

    task automatic report_mismatch(input cpu_pkg::debug_t dbg, input int idx);
        errors++;
        if (idx >= exp_list.size())
            $display("Unexpected write retired at pc %h to r%0d after the last expected one",
                     dbg.pc, dbg.regf);
        else
            $display("[ERROR] %0t debug_o: expected pc=%h r%0d=%h, got pc=%h r%0d=%h", $time,
                     exp_list[idx].pc, exp_list[idx].regf, exp_list[idx].data,
                     dbg.pc, dbg.regf, dbg.data);
    endtask

    retire_check: assert property (@(posedge clk) disable iff (!arst_n)
        debug_o.we |-> matches_expected(debug_o, exp_idx))
        else report_mismatch($sampled(debug_o), $sampled(exp_idx));

    // Back-pressure freezes both requests
    bus_hold_check: assert property (@(posedge clk) disable iff (!arst_n)
        (ibus_rsp.stall || dbus_rsp.stall) |=> ($stable(ibus_req) && $stable(dbus_req)))
        else begin
            errors++;
            $display("Bus request changed at %0t right after a stalled cycle", $time);
        end

    always @(posedge clk) begin
        if (!arst_n)
            exp_idx <= 0;
        else if (debug_o.we)
            exp_idx <= exp_idx + 1;
    end

    always @(posedge clk) begin
        if (!arst_n)
            cycles <= 0;
        else
            cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d retirements seen",
                     cycles, exp_idx, exp_list.size());
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic put_word(input logic [31:0] pc, input logic [31:0] word);
        image[pc[9:2]] = word;
    endtask

    task automatic load_program();
        for (int i = 0; i < WORDS; i++)
            image[i] = 32'ha5c3_0000 ^ (i << 2);   // fill follows the byte address
        put_word(32'h00, enc_i(6'h0f, 0, 1, 16'h8000));       // lui  r1
        put_word(32'h04, enc_i(6'h0d, 0, 2, 16'h0001));       // ori  r2
        put_word(32'h08, enc_r(0, 2, 3, 6'h23));              // subu r3 wraps
        put_word(32'h0c, enc_r(1, 1, 4, 6'h21));              // addu r4 wraps
        put_word(32'h10, enc_r(3, 1, 5, 6'h25));
        put_word(32'h14, enc_r(2, 2, 0, 6'h21));              // write to r0
        put_word(32'h18, enc_i(6'h0d, 2, 6, 16'h8000));
        put_word(32'h1c, enc_r(6, 5, 7, 6'h21));
        put_word(32'h20, enc_i(6'h0d, 0, 8, 16'h0300));       // data pointer
        put_word(32'h24, enc_i(6'h2b, 8, 7, 16'h0000));
        put_word(32'h28, enc_i(6'h23, 8, 9, 16'h0000));
        put_word(32'h2c, enc_r(9, 2, 10, 6'h21));             // load-use
        put_word(32'h30, enc_beq(10, 6, 32'h30, 32'h38));     // taken
        put_word(32'h34, enc_i(6'h0d, 0, 11, 16'hdead));
        put_word(32'h38, enc_beq(10, 7, 32'h38, 32'h40));     // not taken
        put_word(32'h3c, enc_i(6'h0d, 0, 12, 16'h0012));
        put_word(32'h40, enc_i(6'h0d, 0, 20, 16'h0001));      // handler phase
        put_word(32'h44, enc_i(6'h0d, 0, 21, 16'h0001));
        put_word(32'h48, enc_i(6'h0d, 0, 22, 16'h0002));
        put_word(32'h4c, enc_i(6'h23, 8, 13, 16'h0002));      // misaligned lw
        put_word(32'h50, enc_i(6'h0d, 0, 14, 16'h00ee));
        put_word(32'h54, enc_i(6'h0d, 0, 20, 16'h0002));
        put_word(32'h58, enc_i(6'h2b, 8, 2, 16'h0001));       // misaligned sw
        put_word(32'h5c, enc_i(6'h0d, 0, 17, 16'h0077));
        put_word(32'h60, enc_i(6'h23, 8, 15, 16'h0000));
        put_word(32'h64, enc_i(6'h0d, 0, 20, 16'h0003));
        put_word(32'h68, 32'hfc00_0000);                      // reserved opcode
        put_word(32'h6c, enc_i(6'h0d, 0, 18, 16'h0055));
        put_word(32'h70, enc_r(15, 26, 16, 6'h21));
        put_word(32'h74, enc_beq(0, 0, 32'h74, 32'h74));      // spin here
        // Handler returns by phase
        put_word(32'h180, enc_i(6'h0d, 20, 26, 16'h0100));
        put_word(32'h184, enc_beq(20, 21, 32'h184, 32'h54));
        put_word(32'h188, enc_beq(20, 22, 32'h188, 32'h60));
        put_word(32'h18c, enc_beq(0, 0, 32'h18c, 32'h70));
    endtask

    // Instruction-level model of the program
    task automatic build_expected();
        logic [31:0] regs [32];
        logic [31:0] dmem [WORDS];
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        logic [31:0] v;
        logic [4:0]  dst;
        bit          wr;
        bit          fault;
        regs = '{default: '0};
        dmem = image;
        pc = '0;
        steps = 0;
        exp_list.delete();
        for (int n = 0; n < 200; n++) begin
            w = dmem[pc[9:2]];
            if (w[31:26] == 6'h04 && w[25:16] == '0 && w[15:0] == 16'hffff)
                break;
            steps++;
            a = regs[w[25:21]];
            b = regs[w[20:16]];
            sext = {{16{w[15]}}, w[15:0]};
            addr = a + sext;
            dst = w[20:16];
            wr = 1'b0;
            fault = 1'b0;
            v = '0;
            nxt = pc + 32'd4;
            case (w[31:26])
                6'h00: begin
                    dst = w[15:11];
                    wr = 1'b1;
                    case (w[5:0])
                        6'h21: v = a + b;
                        6'h23: v = a - b;
                        6'h25: v = a | b;
                        default: begin
                            wr = 1'b0;
                            fault = (w != '0);   // all zero is a NOP
                        end
                    endcase
                end
                6'h0d: begin
                    v = a | {16'h0000, w[15:0]};
                    wr = 1'b1;
                end
                6'h0f: begin
                    v = {w[15:0], 16'h0000};
                    wr = 1'b1;
                end
                6'h23: begin
                    fault = (addr[1:0] != 2'b00);
                    v = dmem[addr[9:2]];
                    wr = 1'b1;
                end
                6'h2b: begin
                    fault = (addr[1:0] != 2'b00);
                    if (!fault)
                        dmem[addr[9:2]] = b;
                end
                6'h04: begin
                    if (a == b)
                        nxt = pc + 32'd4 + {sext[29:0], 2'b00};
                end
                default: fault = 1'b1;
            endcase
            if (fault) begin
                wr = 1'b0;
                nxt = cpu_pkg::EXC_VECTOR;
            end
            if (wr && dst != 5'd0) begin
                regs[dst] = v;
                exp_list.push_back('{pc: pc, we: 1'b1, regf: dst, data: v});
            end
            pc = nxt;
        end
    endtask

    task automatic run_program(input bit with_stalls, input string name);
        int errors_before;
        errors_before = errors;
        @(posedge clk);
        arst_n   <= 1'b0;
        stall_en <= with_stalls;
        for (int i = 0; i < WORDS; i++)
            bus_memory.mem[i] = image[i];
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        while (exp_idx < exp_list.size())
            @(posedge clk);
        repeat (DRAIN) @(posedge clk);
        count_check: assert (exp_idx == exp_list.size()) else begin
            errors++;
            $display("%0d retirements appeared on debug_o where %0d were expected",
                     exp_idx, exp_list.size());
        end
        if (errors != errors_before)
            failed_tests++;
        $display("Test %s: %0d retirements, %0d errors", name, exp_idx, errors - errors_before);
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        stall_en = 1'b0;
        errors = 0;
        failed_tests = 0;
        void'($urandom(32'hb399a8fa));
        load_program();
        build_expected();
        cycle_limit = 4 * steps + 2 * STALL_MAX + DRAIN + 20;
        run_program(1'b0, "no bus stalls");
        run_program(1'b1, "random bus stalls");
        $display("Tests: 2, failed: %0d, errors: %0d", failed_tests, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule
